/* design/lc_pkg.sv */
//////////////////////////////////////////////////
// link controller shared definitions
// sync word and counter widths, link state and
// correlator mode encodings, slot timing
//////////////////////////////////////////////////
package lc_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////

  // access code sync word
  localparam int SYNC_W = 64;
  typedef logic [SYNC_W-1:0] sync_word_t;

  // microsecond count, two slots fit
  typedef logic [10:0] us_count_t;

  // scan interval and window, in slots
  typedef logic [15:0] slot_count_t;

  // agreeing bits, 0..64
  typedef logic [6:0] corr_sum_t;

  // programmable correlation threshold
  typedef logic [6:0] thresh_t;

  //////////////////////////////////////////////////
  // encodings
  //////////////////////////////////////////////////

  // slave side link states
  typedef enum logic [3:0] {
    STANDBY,
    PAGE_SCAN,
    PAGE_SCAN_1MORE,
    SR_TXID,
    SR_RXFHS,
    SR_RXFHS_DONE,
    SR_ACKFHS,
    NEW_SLAVE,
    NEW_SLAVE_ACKPOLL,
    CONN_ACTIVE
  } link_state_e;

  // which reference word and window the correlator uses
  typedef enum logic [1:0] {
    CORR_OFF,
    CORR_SCAN,
    CORR_RESP,
    CORR_CONN
  } corr_mode_e;

  //////////////////////////////////////////////////
  // slot timing
  //////////////////////////////////////////////////

  // last count of a 625 us slot
  localparam us_count_t SLOT_US_LAST = 11'd624;
  // ID turnaround, roughly half a slot
  localparam us_count_t HALF_SLOT_US_LAST = 11'd311;
  // slots in SR_RXFHS before giving up on the FHS
  localparam logic [3:0] PAGE_RESP_TO_SLOTS = 4'd8;
  // master slots without a poll before dropping the new link
  localparam logic [4:0] NEW_CONN_TO_SLOTS = 5'd16;

endpackage

/* design/corr_lane_if.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// one correlator lane
// slices in from the feeder, bit count out to the drain
//////////////////////////////////////////////////
interface corr_lane_if #(
  parameter int N_LANES = 4
) ();

  localparam int LANE_W = lc_pkg::SYNC_W / N_LANES;
  // count must reach LANE_W itself
  localparam int CNT_W  = $clog2(LANE_W + 1);

  logic [LANE_W-1:0] ref_slice;
  logic [LANE_W-1:0] rx_slice;
  logic              sample_valid;
  logic [CNT_W-1:0]  agree_count;
  logic              count_valid;

  modport feed (output ref_slice, rx_slice, sample_valid);
  modport lane (input ref_slice, rx_slice, sample_valid, output agree_count, count_valid);
  modport drain (input agree_count, count_valid);

endinterface

/* design/sync_ref_select.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// correlator front end
// picks DAC or CAC and the sample window by mode,
// registers one sample and deals it out to the lanes
//////////////////////////////////////////////////
module sync_ref_select #(
  parameter int N_LANES = 4
) (
  input  logic               clk_6M,
  input  logic               rstz,
  input  lc_pkg::sync_word_t sync_in,
  input  lc_pkg::sync_word_t syncword_dac,
  input  lc_pkg::sync_word_t syncword_cac,
  input  lc_pkg::corr_mode_e corr_mode,
  input  logic               scan_open,
  corr_lane_if.feed          lanes [N_LANES]
);

  localparam int LANE_W = lc_pkg::SYNC_W / N_LANES;

  lc_pkg::sync_word_t ref_word;
  logic               win_open;
  lc_pkg::sync_word_t rx_q;
  lc_pkg::sync_word_t ref_q;
  logic               valid_q;

  // DAC while scanning and responding, CAC once connected
  always_comb
  begin
    ref_word = syncword_dac;
    win_open = 1'b0;
    case (corr_mode)
      lc_pkg::CORR_SCAN: win_open = scan_open;
      lc_pkg::CORR_RESP: win_open = 1'b1;
      lc_pkg::CORR_CONN:
      begin
        ref_word = syncword_cac;
        win_open = 1'b1;
      end
      default: win_open = 1'b0;
    endcase
  end

  // received word and its reference kept as a pair
  always_ff @(posedge clk_6M)
  begin
    if (win_open)
    begin
      rx_q  <= sync_in;
      ref_q <= ref_word;
    end
  end

  // valid trails the sampling edge by one cycle
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      valid_q <= 1'b0;
    else
      valid_q <= win_open;
  end

  // lane g gets bits [g*LANE_W +: LANE_W]
  for (genvar g = 0; g < N_LANES; g++)
  begin : g_split
    assign lanes[g].rx_slice     = rx_q[g*LANE_W +: LANE_W];
    assign lanes[g].ref_slice    = ref_q[g*LANE_W +: LANE_W];
    assign lanes[g].sample_valid = valid_q;
  end

endmodule

/* design/corr_lane.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// correlator lane
// registered count of agreeing bits in one slice
//////////////////////////////////////////////////
module corr_lane (
  input  logic      clk_6M,
  input  logic      rstz,
  corr_lane_if.lane lane
);

  // slice and count widths follow the interface
  localparam int LANE_W = $bits(lane.rx_slice);
  localparam int CNT_W  = $bits(lane.agree_count);

  logic [LANE_W-1:0] agree_bits;
  logic [CNT_W-1:0]  ones;

  // 1 where received and reference bits match
  assign agree_bits = ~(lane.rx_slice ^ lane.ref_slice);

  always_comb
  begin
    ones = '0;
    for (int i = 0; i < LANE_W; i++)
      ones = ones + CNT_W'(agree_bits[i]);
  end

  // count only loaded with a fresh sample
  always_ff @(posedge clk_6M)
  begin
    if (lane.sample_valid)
      lane.agree_count <= ones;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      lane.count_valid <= 1'b0;
    else
      lane.count_valid <= lane.sample_valid;
  end

endmodule

/* design/corr_threshold.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// correlator back end
// lane sum against threshold, then the slot and
// half-slot delay timer that follows a hit
//////////////////////////////////////////////////
module corr_threshold #(
  parameter int N_LANES = 4
) (
  input  logic            clk_6M,
  input  logic            rstz,
  input  logic            p_1us,
  input  lc_pkg::thresh_t corr_threshold_val,
  corr_lane_if.drain      lanes [N_LANES],
  output logic            corr_hit,
  output logic            slot_dly_endp,
  output logic            half_slot_dly_endp
);

  localparam int LANE_W = lc_pkg::SYNC_W / N_LANES;
  localparam int CNT_W  = $clog2(LANE_W + 1);

  logic [CNT_W-1:0]   lane_cnt [N_LANES];
  logic [N_LANES-1:0] lane_vld;
  lc_pkg::corr_sum_t  corr_sum;
  lc_pkg::us_count_t  us_cnt;
  logic               tmr_run;

  // lane counts and valids gathered per lane
  for (genvar g = 0; g < N_LANES; g++)
  begin : g_gather
    assign lane_cnt[g] = lanes[g].agree_count;
    assign lane_vld[g] = lanes[g].count_valid;
  end

  always_comb
  begin
    corr_sum = '0;
    for (int i = 0; i < N_LANES; i++)
      corr_sum = corr_sum + lc_pkg::corr_sum_t'(lane_cnt[i]);
  end

  // third pipeline stage, one cycle per sample
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      corr_hit <= 1'b0;
    else
      corr_hit <= (&lane_vld) && (corr_sum >= corr_threshold_val);
  end

  //////////////////////////////////////////////////
  // post-hit delay timer
  //////////////////////////////////////////////////

  // restarts on every hit, then wraps each slot so the
  // half-slot mark also lands in the slot after
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tmr_run <= 1'b0;
      us_cnt  <= '0;
    end
    else if (corr_hit)
    begin
      tmr_run <= 1'b1;
      us_cnt  <= '0;
    end
    else if (tmr_run && p_1us)
    begin
      if (us_cnt == lc_pkg::SLOT_US_LAST)
        us_cnt <= '0;
      else
        us_cnt <= us_cnt + 1'b1;
    end
  end

  // a hit in the same cycle supersedes the old count
  assign slot_dly_endp = tmr_run && p_1us && !corr_hit &&
                         (us_cnt == lc_pkg::SLOT_US_LAST);
  assign half_slot_dly_endp = tmr_run && p_1us && !corr_hit &&
                              (us_cnt == lc_pkg::HALF_SLOT_US_LAST);

endmodule

/* design/scan_window.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// page scan window
// enable latch plus interval and window slot counters
//////////////////////////////////////////////////
module scan_window (
  input  logic                clk_6M,
  input  logic                rstz,
  input  logic                tslot_p,
  input  logic                page_scan_enable,
  input  logic                page_scan_cancel,
  input  logic                scan_done,
  input  lc_pkg::slot_count_t ps_interval,
  input  lc_pkg::slot_count_t ps_window,
  output logic                scan_open
);

  logic                scan_en;
  logic                armed;
  lc_pkg::slot_count_t ivl_cnt;
  lc_pkg::slot_count_t ivl_next;
  lc_pkg::slot_count_t win_cnt;

  // enable wins over a cancel in the same cycle
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      scan_en <= 1'b0;
    else if (page_scan_enable)
      scan_en <= 1'b1;
    else if (page_scan_cancel || scan_done)
      scan_en <= 1'b0;
  end

  assign ivl_next = ivl_cnt + 1'b1;

  //////////////////////////////////////////////////
  // window counters
  //////////////////////////////////////////////////

  // armed drops with the latch so the next enable
  // opens again on its first slot boundary
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      scan_open <= 1'b0;
      armed     <= 1'b0;
      ivl_cnt   <= '0;
      win_cnt   <= '0;
    end
    else if (!scan_en)
    begin
      scan_open <= 1'b0;
      armed     <= 1'b0;
    end
    else if (tslot_p)
    begin
      // first boundary after enable, or interval elapsed
      if (!armed || ivl_next == ps_interval)
      begin
        armed     <= 1'b1;
        scan_open <= 1'b1;
        ivl_cnt   <= '0;
        win_cnt   <= lc_pkg::slot_count_t'(1);
      end
      else
      begin
        ivl_cnt <= ivl_next;
        // close after ps_window slots
        if (win_cnt == ps_window)
          scan_open <= 1'b0;
        else
          win_cnt <= win_cnt + 1'b1;
      end
    end
  end

endmodule

/* design/link_fsm.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// slave link state machine
// page scan, page response and new connection,
// with the page-response and new-connection timeouts
//////////////////////////////////////////////////
module link_fsm (
  input  logic               clk_6M,
  input  logic               rstz,
  input  logic               p_1us,
  input  logic               tslot_p,
  input  logic               clk1,
  input  logic               scan_open,
  input  logic               corr_hit,
  input  logic               slot_dly_endp,
  input  logic               half_slot_dly_endp,
  input  logic               rx_is_fhs,
  input  logic               hec_good,
  input  logic               crc_good,
  input  logic               rx_is_poll,
  input  logic               lt_addressed,
  output lc_pkg::corr_mode_e corr_mode,
  output logic               scan_done,
  output logic               ps,
  output logic               spr,
  output logic               conns,
  output logic               conns_new_slave,
  output logic               fhs_rx_ok_p,
  output logic               page_resp_to
);

  lc_pkg::link_state_e cs;
  lc_pkg::link_state_e ns;
  logic                hit_seen;
  logic                fhs_ok;
  logic [3:0]          resp_cnt;
  logic [4:0]          conn_cnt;
  logic                resp_to;
  logic                conn_to;

  //////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////

  // one step per microsecond strobe
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      cs <= lc_pkg::STANDBY;
    else if (p_1us)
      cs <= ns;
  end

  // hit is a single clock, hold it until the state moves on
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      hit_seen <= 1'b0;
    else if (corr_hit)
      hit_seen <= 1'b1;
    else if (p_1us && ns != cs)
      hit_seen <= 1'b0;
  end

  assign fhs_ok = hit_seen && rx_is_fhs && hec_good && crc_good;

  always_comb
  begin
    ns = cs;
    case (cs)
      lc_pkg::STANDBY:
        if (scan_open)
          ns = lc_pkg::PAGE_SCAN;
      // 1MORE is a second chance at the same scan
      lc_pkg::PAGE_SCAN, lc_pkg::PAGE_SCAN_1MORE:
        if (!scan_open)
          ns = lc_pkg::STANDBY;
        else if (hit_seen && slot_dly_endp)
          ns = lc_pkg::SR_TXID;
      // ID goes out, then listen half a slot later
      lc_pkg::SR_TXID:
        if (half_slot_dly_endp)
          ns = lc_pkg::SR_RXFHS;
      lc_pkg::SR_RXFHS:
        if (resp_to)
          ns = lc_pkg::PAGE_SCAN_1MORE;
        else if (fhs_ok)
          ns = lc_pkg::SR_RXFHS_DONE;
      lc_pkg::SR_RXFHS_DONE:
        if (tslot_p)
          ns = lc_pkg::SR_ACKFHS;
      lc_pkg::SR_ACKFHS:
        if (tslot_p)
          ns = lc_pkg::NEW_SLAVE;
      // wait for the master's poll on the channel code
      lc_pkg::NEW_SLAVE:
        if (hit_seen && rx_is_poll && lt_addressed && tslot_p)
          ns = lc_pkg::NEW_SLAVE_ACKPOLL;
        else if (conn_to)
          ns = lc_pkg::PAGE_SCAN;
      lc_pkg::NEW_SLAVE_ACKPOLL:
        if (tslot_p)
          ns = lc_pkg::CONN_ACTIVE;
      default:
        ns = cs;
    endcase
  end

  //////////////////////////////////////////////////
  // timeouts
  //////////////////////////////////////////////////

  // slots spent waiting for the FHS, saturating
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      resp_cnt <= '0;
    else if (cs != lc_pkg::SR_RXFHS)
      resp_cnt <= '0;
    else if (tslot_p && !resp_to)
      resp_cnt <= resp_cnt + 1'b1;
  end

  assign resp_to = (resp_cnt == lc_pkg::PAGE_RESP_TO_SLOTS);

  // only master-to-slave slots count, clk1 high
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      conn_cnt <= '0;
    else if (cs != lc_pkg::NEW_SLAVE)
      conn_cnt <= '0;
    else if (tslot_p && clk1 && !conn_to)
      conn_cnt <= conn_cnt + 1'b1;
  end

  assign conn_to = (conn_cnt == lc_pkg::NEW_CONN_TO_SLOTS);

  //////////////////////////////////////////////////
  // state decode
  //////////////////////////////////////////////////

  always_comb
  begin
    case (cs)
      lc_pkg::STANDBY:
        corr_mode = lc_pkg::CORR_OFF;
      lc_pkg::PAGE_SCAN, lc_pkg::PAGE_SCAN_1MORE:
        corr_mode = lc_pkg::CORR_SCAN;
      lc_pkg::SR_TXID, lc_pkg::SR_RXFHS, lc_pkg::SR_RXFHS_DONE, lc_pkg::SR_ACKFHS:
        corr_mode = lc_pkg::CORR_RESP;
      default:
        corr_mode = lc_pkg::CORR_CONN;
    endcase
  end

  assign ps = (cs == lc_pkg::PAGE_SCAN) || (cs == lc_pkg::PAGE_SCAN_1MORE);
  assign spr = (cs == lc_pkg::SR_TXID) || (cs == lc_pkg::SR_RXFHS) ||
               (cs == lc_pkg::SR_RXFHS_DONE) || (cs == lc_pkg::SR_ACKFHS);
  assign conns_new_slave = (cs == lc_pkg::NEW_SLAVE) || (cs == lc_pkg::NEW_SLAVE_ACKPOLL);
  // new slave already counts as connected
  assign conns = conns_new_slave || (cs == lc_pkg::CONN_ACTIVE);

  // pulses ride on the edge that takes the transition
  assign page_resp_to = (cs == lc_pkg::SR_RXFHS) && p_1us && resp_to;
  assign fhs_rx_ok_p  = (cs == lc_pkg::SR_RXFHS) && p_1us && !resp_to && fhs_ok;
  // scan latch drops once the ID for the FHS is out
  assign scan_done    = (cs == lc_pkg::SR_ACKFHS) && p_1us && tslot_p;

endmodule

/* design/link_ctrl_top.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// slave link controller top
// correlator pipeline, scan window and link FSM
//////////////////////////////////////////////////
module link_ctrl_top #(
  parameter int N_LANES = 4
) (
  input  logic                clk_6M,
  input  logic                rstz,
  input  logic                p_1us,
  input  logic                tslot_p,
  input  logic                clk1,
  input  lc_pkg::sync_word_t  sync_in,
  input  lc_pkg::sync_word_t  syncword_dac,
  input  lc_pkg::sync_word_t  syncword_cac,
  input  lc_pkg::thresh_t     corr_threshold_val,
  input  logic                page_scan_enable,
  input  logic                page_scan_cancel,
  input  lc_pkg::slot_count_t ps_interval,
  input  lc_pkg::slot_count_t ps_window,
  input  logic                rx_is_fhs,
  input  logic                hec_good,
  input  logic                crc_good,
  input  logic                rx_is_poll,
  input  logic                lt_addressed,
  output logic                ps,
  output logic                spr,
  output logic                conns,
  output logic                conns_new_slave,
  output logic                corr_hit,
  output logic                fhs_rx_ok_p,
  output logic                page_resp_to
);

  lc_pkg::corr_mode_e corr_mode;
  logic               scan_open;
  logic               scan_done;
  logic               slot_dly_endp;
  logic               half_slot_dly_endp;

  // one link per lane between the three correlator stages
  corr_lane_if #(.N_LANES(N_LANES)) lane_if [N_LANES] ();

  //////////////////////////////////////////////////
  // correlator
  //////////////////////////////////////////////////

  sync_ref_select #(.N_LANES(N_LANES)) sync_ref_select_i (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .sync_in      (sync_in),
    .syncword_dac (syncword_dac),
    .syncword_cac (syncword_cac),
    .corr_mode    (corr_mode),
    .scan_open    (scan_open),
    .lanes        (lane_if)
  );

  for (genvar g = 0; g < N_LANES; g++)
  begin : g_lane
    corr_lane corr_lane_i (
      .clk_6M (clk_6M),
      .rstz   (rstz),
      .lane   (lane_if[g])
    );
  end

  corr_threshold #(.N_LANES(N_LANES)) corr_threshold_i (
    .clk_6M             (clk_6M),
    .rstz               (rstz),
    .p_1us              (p_1us),
    .corr_threshold_val (corr_threshold_val),
    .lanes              (lane_if),
    .corr_hit           (corr_hit),
    .slot_dly_endp      (slot_dly_endp),
    .half_slot_dly_endp (half_slot_dly_endp)
  );

  //////////////////////////////////////////////////
  // scan timing and link control
  //////////////////////////////////////////////////

  scan_window scan_window_i (
    .clk_6M           (clk_6M),
    .rstz             (rstz),
    .tslot_p          (tslot_p),
    .page_scan_enable (page_scan_enable),
    .page_scan_cancel (page_scan_cancel),
    .scan_done        (scan_done),
    .ps_interval      (ps_interval),
    .ps_window        (ps_window),
    .scan_open        (scan_open)
  );

  link_fsm link_fsm_i (
    .clk_6M             (clk_6M),
    .rstz               (rstz),
    .p_1us              (p_1us),
    .tslot_p            (tslot_p),
    .clk1               (clk1),
    .scan_open          (scan_open),
    .corr_hit           (corr_hit),
    .slot_dly_endp      (slot_dly_endp),
    .half_slot_dly_endp (half_slot_dly_endp),
    .rx_is_fhs          (rx_is_fhs),
    .hec_good           (hec_good),
    .crc_good           (crc_good),
    .rx_is_poll         (rx_is_poll),
    .lt_addressed       (lt_addressed),
    .corr_mode          (corr_mode),
    .scan_done          (scan_done),
    .ps                 (ps),
    .spr                (spr),
    .conns              (conns),
    .conns_new_slave    (conns_new_slave),
    .fhs_rx_ok_p        (fhs_rx_ok_p),
    .page_resp_to       (page_resp_to)
  );

endmodule

/* verification/tb_ref_model.svh */
//////////////////////////////////////////////////
// reference model for the link controller testbench
// correlation result, scan window and status decode
//////////////////////////////////////////////////
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// model states, numbered for the status table only
localparam int M_STANDBY   = 0;
localparam int M_PAGE_SCAN = 1;
localparam int M_RESPONSE  = 2;
localparam int M_NEW_SLAVE = 3;
localparam int M_CONNECTED = 4;

// bits where the received word equals the reference
function automatic int count_agreeing(input logic [63:0] rx, input logic [63:0] ref_w);
  int n;
  n = 0;
  for (int i = 0; i < 64; i++)
  begin
    if (rx[i] == ref_w[i])
      n++;
  end
  return n;
endfunction

// hit when the agreement reaches the threshold
function automatic logic expect_hit(input logic [63:0] rx, input logic [63:0] ref_w,
                                    input int thr);
  return (count_agreeing(rx, ref_w) >= thr) ? 1'b1 : 1'b0;
endfunction

// slot k counted from the first opening
// open for win slots, reopened every ivl slots
function automatic logic scan_open_in_slot(input int k, input int win, input int ivl);
  return ((k % ivl) < win) ? 1'b1 : 1'b0;
endfunction

// status outputs as {ps, spr, conns_new_slave, conns}
function automatic logic [3:0] status_bits(input int st);
  case (st)
    M_PAGE_SCAN: return 4'b1000;
    M_RESPONSE:  return 4'b0100;
    // new slave is already a connection
    M_NEW_SLAVE: return 4'b0011;
    M_CONNECTED: return 4'b0001;
    default:     return 4'b0000;
  endcase
endfunction

`endif

/* verification/tb_link_ctrl.sv */
`timescale 1ns/1ps
//////////////////////////////////////////////////
// link controller testbench
// random sync words against the reference model,
// scan window, slave response and both timeouts
//////////////////////////////////////////////////
module tb_link_ctrl;

  localparam int SLOT_CYCLES = 3750;
  // scan 16, corr 3, response 7, resp timeout 12, conn timeout 40
  localparam int TEST_SLOTS  = 16 + 3 + 7 + 12 + 40;
  localparam int MAX_CYCLES  = (TEST_SLOTS + 30) * SLOT_CYCLES;

  logic clk_6M = 1'b0;
  logic rstz, p_1us, tslot_p, clk1;
  logic [63:0] sync_in, dac, cac;
  logic [6:0] thr;
  logic page_scan_enable, page_scan_cancel;
  logic [15:0] ps_interval, ps_window;
  logic rx_is_fhs, hec_good, crc_good, rx_is_poll, lt_addressed;
  logic ps, spr, conns, conns_new_slave, corr_hit, fhs_rx_ok_p, page_resp_to;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int failed = 0;
  int start_err;
  int strobe_cyc = 0;
  int cyc_total = 0;
  string cur_test;

  `include "tb_ref_model.svh"

  link_ctrl_top #(.N_LANES(4)) link_ctrl_top_i (
    .clk_6M(clk_6M), .rstz(rstz), .p_1us(p_1us), .tslot_p(tslot_p), .clk1(clk1),
    .sync_in(sync_in), .syncword_dac(dac), .syncword_cac(cac),
    .corr_threshold_val(thr), .page_scan_enable(page_scan_enable),
    .page_scan_cancel(page_scan_cancel), .ps_interval(ps_interval),
    .ps_window(ps_window), .rx_is_fhs(rx_is_fhs), .hec_good(hec_good),
    .crc_good(crc_good), .rx_is_poll(rx_is_poll), .lt_addressed(lt_addressed),
    .ps(ps), .spr(spr), .conns(conns), .conns_new_slave(conns_new_slave),
    .corr_hit(corr_hit), .fhs_rx_ok_p(fhs_rx_ok_p), .page_resp_to(page_resp_to)
  );

  always #10 clk_6M = ~clk_6M;

  // 1 us strobe every sixth clock, slot strobe every 625 us
  always @(posedge clk_6M)
  begin
    #1;
    strobe_cyc = (strobe_cyc + 1) % SLOT_CYCLES;
    if (tslot_p)
      clk1 = ~clk1;
    p_1us   = (strobe_cyc % 6 == 5);
    tslot_p = (strobe_cyc == SLOT_CYCLES - 1);
  end

  // run limit
  always @(posedge clk_6M)
  begin
    cyc_total++;
    if (cyc_total == MAX_CYCLES)
    begin
      $display("run stopped after %0d cycles without finishing", cyc_total);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (exp === act)
    else
    begin
      $display("ERROR %s %s: expected %0h actual %0h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_status(input int st);
    check("status", status_bits(st), {ps, spr, conns_new_slave, conns});
  endtask

  function automatic logic out_sel(input int which);
    case (which)
      0: return ps;
      1: return spr;
      2: return conns_new_slave;
      3: return fhs_rx_ok_p;
      default: return page_resp_to;
    endcase
  endfunction

  // poll an output at negedges, give up after max_cyc
  task automatic wait_out(input int which, input logic val, input int max_cyc,
                          input string what);
    int n;
    bit ok;
    n = 0;
    ok = 0;
    while (!ok && n < max_cyc)
    begin
      @(negedge clk_6M);
      ok = (out_sel(which) === val);
      n++;
    end
    assert (ok)
    else
    begin
      $display("%s: %s never happened", cur_test, what);
      errors++;
    end
  endtask

  task automatic drive_word(input logic [63:0] w);
    @(posedge clk_6M);
    #1 sync_in = w;
  endtask

  task automatic pulse_enable(input bit cancel);
    @(posedge clk_6M);
    #1;
    page_scan_enable = !cancel;
    page_scan_cancel = cancel;
    @(posedge clk_6M);
    #1;
    page_scan_enable = 1'b0;
    page_scan_cancel = 1'b0;
  endtask

  task automatic apply_reset(input logic [15:0] win, input logic [15:0] ivl);
    rstz = 1'b0;
    sync_in = ~dac;
    page_scan_enable = 1'b0;
    page_scan_cancel = 1'b0;
    rx_is_fhs = 1'b0;
    hec_good = 1'b0;
    crc_good = 1'b0;
    rx_is_poll = 1'b0;
    lt_addressed = 1'b0;
    ps_window = win;
    ps_interval = ivl;
    repeat (3) @(posedge clk_6M);
    #1 rstz = 1'b1;
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    start_err = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors != start_err)
      failed++;
    $display("test %s: %s", cur_test, (errors == start_err) ? "pass" : "FAIL");
  endtask

  function automatic logic [63:0] flip_bits(input int n);
    logic [63:0] m;
    m = '0;
    while ($countones(m) < n)
      m[$urandom_range(0, 63)] = 1'b1;
    return m;
  endfunction

  // hit seen 3 cycles after the sampling edge, last 3 words idle
  task automatic run_corr(input logic [63:0] ref_w, input int words);
    logic exp_q[$];
    logic [63:0] w;
    logic e;
    for (int i = 0; i < words + 3; i++)
    begin
      w = (i < words) ? (ref_w ^ flip_bits($urandom_range(0, 40))) : ~dac;
      drive_word(w);
      exp_q.push_back(expect_hit(w, ref_w, thr));
      @(negedge clk_6M);
      if (exp_q.size() == 4)
      begin
        e = exp_q.pop_front();
        check("corr_hit", e, corr_hit);
      end
    end
  endtask

  // scan hit, then wait out the ID half slot and send a good FHS
  task automatic respond_fhs();
    drive_word(dac);
    drive_word(~dac);
    wait_out(1, 1'b1, 2 * SLOT_CYCLES, "spr after the scan hit");
    check_status(M_RESPONSE);
    repeat (2400) @(posedge clk_6M);
    #1;
    rx_is_fhs = 1'b1;
    hec_good = 1'b1;
    crc_good = 1'b1;
    drive_word(dac);
    drive_word(~dac);
    wait_out(3, 1'b1, 100, "fhs_rx_ok_p");
    @(posedge clk_6M);
    #1 rx_is_fhs = 1'b0;
    wait_out(2, 1'b1, 3 * SLOT_CYCLES, "conns_new_slave");
    check_status(M_NEW_SLAVE);
  endtask

  initial
  begin
    int n;
    void'($urandom(32'h2238_476a));
    p_1us = 1'b0;
    tslot_p = 1'b0;
    clk1 = 1'b0;
    dac = {$urandom(), $urandom()};
    cac = dac ^ 64'h0000_0000_ffff_ffff;
    thr = 7'd64;
    apply_reset(16'd2, 16'd4);

    begin_test("reset_state");
    // full agreement, yet standby keeps the correlator closed
    drive_word(dac);
    repeat (200)
    begin
      @(negedge clk_6M);
      check("corr_hit", 1'b0, corr_hit);
    end
    check_status(M_STANDBY);
    check("page_resp_to", 1'b0, page_resp_to);
    check("fhs_rx_ok_p", 1'b0, fhs_rx_ok_p);
    drive_word(~dac);
    end_test();

    begin_test("scan_window");
    for (int pass = 0; pass < 2; pass++)
    begin
      pulse_enable(0);
      @(negedge clk_6M);
      while (tslot_p !== 1'b1)
        @(negedge clk_6M);
      repeat (SLOT_CYCLES / 2) @(negedge clk_6M);
      for (int k = 0; k < 8 - 4 * pass; k++)
      begin
        check("ps", scan_open_in_slot(k, 2, 4), ps);
        repeat (SLOT_CYCLES) @(negedge clk_6M);
      end
      pulse_enable(1);
      repeat (10) @(negedge clk_6M);
      check("ps", 1'b0, ps);
    end
    end_test();

    begin_test("corr_threshold");
    apply_reset(16'hffff, 16'd0);
    thr = 7'($urandom_range(24, 63));
    pulse_enable(0);
    wait_out(0, 1'b1, 2 * SLOT_CYCLES, "ps after enable");
    run_corr(dac, 300);
    end_test();

    begin_test("slave_response");
    apply_reset(16'hffff, 16'd0);
    thr = 7'd60;
    pulse_enable(0);
    wait_out(0, 1'b1, 2 * SLOT_CYCLES, "ps after enable");
    check_status(M_PAGE_SCAN);
    respond_fhs();
    drive_word(cac);
    rx_is_poll = 1'b1;
    lt_addressed = 1'b1;
    drive_word(~dac);
    wait_out(2, 1'b0, 3 * SLOT_CYCLES, "move from new slave to active");
    check_status(M_CONNECTED);
    @(posedge clk_6M);
    #1;
    rx_is_poll = 1'b0;
    lt_addressed = 1'b0;
    thr = 7'($urandom_range(24, 63));
    run_corr(cac, 300);
    end_test();

    begin_test("page_resp_timeout");
    apply_reset(16'hffff, 16'd0);
    thr = 7'd60;
    pulse_enable(0);
    wait_out(0, 1'b1, 2 * SLOT_CYCLES, "ps after enable");
    drive_word(dac);
    drive_word(~dac);
    wait_out(1, 1'b1, 2 * SLOT_CYCLES, "spr after the scan hit");
    wait_out(4, 1'b1, 10 * SLOT_CYCLES, "page_resp_to pulse");
    repeat (12) @(negedge clk_6M);
    check_status(M_PAGE_SCAN);
    end_test();

    // continues from the extra page scan left by the last test
    begin_test("new_conn_timeout");
    respond_fhs();
    n = 0;
    while (conns === 1'b1 && cyc_total < MAX_CYCLES)
    begin
      @(negedge clk_6M);
      if (tslot_p && clk1 && conns_new_slave)
        n++;
    end
    check("ps", 1'b1, ps);
    check("slots", 16, n);
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

/* compile.f */
+incdir+verification
design/lc_pkg.sv
design/corr_lane_if.sv
design/sync_ref_select.sv
design/corr_lane.sv
design/corr_threshold.sv
design/scan_window.sv
design/link_fsm.sv
design/link_ctrl_top.sv
verification/tb_link_ctrl.sv

/* run_sim.sh */
#!/bin/bash
# build and run the link controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_link_ctrl -o sim_link_ctrl > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_link_ctrl > sim.log 2>&1
cat sim.log

grep -q "Done: errors found" sim.log \
  && { echo "simulation FAILED"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
